// File: all.f
+incdir+tests
design/alu_pkg.sv
design/alu_decoder.sv
design/alu_branch_kill.sv
design/alu_operand_fwd.sv
design/alu_exec.sv
design/alu_pipe.sv
tests/tb_alu_pipe.sv

// File: design/alu_branch_kill.sv
`timescale 1ns/1ps
`default_nettype none

module alu_branch_kill (
  input  logic                           i_clk,
  input  logic                           i_reset_n,
  input  logic                           i_valid,
  input  logic [alu_pkg::BR_TAG_NUM-1:0] i_br_mask,
  input  logic                           i_br_update,
  input  logic [alu_pkg::BR_TAG_W-1:0]   i_br_tag,
  input  logic                           i_br_mispredict,
  output logic                           o_valid,
  output logic [alu_pkg::BR_TAG_NUM-1:0] o_br_mask
);

  import alu_pkg::*;

  logic                  w_kill;
  logic [BR_TAG_NUM-1:0] w_mask_next;

  // Instruction depends on the mispredicted branch
  assign w_kill = i_br_update & i_br_mispredict & i_br_mask[i_br_tag];

  always_comb begin
    w_mask_next = i_br_mask;
    if (i_br_update) begin
      w_mask_next[i_br_tag] = 1'b0;  // Branch resolved
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid   <= 1'b0;
      o_br_mask <= '0;
    end else begin
      o_valid   <= i_valid & ~w_kill;
      o_br_mask <= w_mask_next;
    end
  end

  // Update strobe comes from the branch unit every cycle
  a_br_update_known : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !$isunknown(i_br_update)
  ) else $error("branch update strobe is unknown");

endmodule

`default_nettype wire

// File: design/alu_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module alu_decoder (
  input  logic [31:0]   i_inst,
  output alu_pkg::op_t  o_op,
  output alu_pkg::imm_t o_imm
);

  import alu_pkg::*;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic       w_alt;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];
  assign w_alt    = i_inst[30];  // SUB / SRA select

  always_comb begin
    o_op  = OP_NOP;
    o_imm = IMM_NONE;
    case (w_opcode)
      OPC_OP: begin
        case (w_funct3)
          F3_ADD_SUB: o_op = w_alt ? OP_SUB : OP_ADD;
          F3_SLL:     o_op = OP_SLL;
          F3_SLT:     o_op = OP_SLT;
          F3_SLTU:    o_op = OP_SLTU;
          F3_XOR:     o_op = OP_XOR;
          F3_SRL_SRA: o_op = w_alt ? OP_SRA : OP_SRL;
          F3_OR:      o_op = OP_OR;
          F3_AND:     o_op = OP_AND;
          default:    o_op = OP_NOP;
        endcase
      end
      OPC_OP_IMM: begin
        o_imm = IMM_I;
        case (w_funct3)
          F3_ADD_SUB: o_op = OP_ADD;  // No SUBI
          F3_SLL: begin
            o_op  = OP_SLL;
            o_imm = IMM_SH;
          end
          F3_SLT:     o_op = OP_SLT;
          F3_SLTU:    o_op = OP_SLTU;
          F3_XOR:     o_op = OP_XOR;
          F3_SRL_SRA: begin
            o_op  = w_alt ? OP_SRA : OP_SRL;
            o_imm = IMM_SH;
          end
          F3_OR:      o_op = OP_OR;
          F3_AND:     o_op = OP_AND;
          default:    o_op = OP_NOP;
        endcase
      end
      OPC_LUI: begin
        o_op = OP_LUI;  // Upper immediate taken in exec
      end
      default: begin
        o_op  = OP_NOP;
        o_imm = IMM_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
  input  alu_pkg::op_t                i_op,
  input  logic [31:0]                 i_inst,
  input  logic [alu_pkg::XLEN_W-1:0]  i_rs1,
  input  logic [alu_pkg::XLEN_W-1:0]  i_rs2,
  output logic [alu_pkg::XLEN_W-1:0]  o_result
);

  import alu_pkg::*;

  logic [SHAMT_W-1:0] w_shamt;
  logic               w_lt_signed;
  logic               w_lt_unsigned;
  logic [XLEN_W-1:0]  w_upper_imm;

  assign w_shamt       = i_rs2[SHAMT_W-1:0];
  assign w_lt_signed   = $signed(i_rs1) < $signed(i_rs2);
  assign w_lt_unsigned = i_rs1 < i_rs2;
  assign w_upper_imm   = {i_inst[31:12], 12'h000};

  always_comb begin
    case (i_op)
      OP_ADD: begin
        o_result = i_rs1 + i_rs2;
      end
      OP_SUB: begin
        o_result = i_rs1 - i_rs2;
      end
      OP_XOR: begin
        o_result = i_rs1 ^ i_rs2;
      end
      OP_OR: begin
        o_result = i_rs1 | i_rs2;
      end
      OP_AND: begin
        o_result = i_rs1 & i_rs2;
      end
      OP_SLL: begin
        o_result = i_rs1 << w_shamt;
      end
      OP_SRL: begin
        o_result = i_rs1 >> w_shamt;
      end
      OP_SRA: begin
        o_result = $signed(i_rs1) >>> w_shamt;  // Keeps sign
      end
      OP_SLT: begin
        o_result = {{(XLEN_W-1){1'b0}}, w_lt_signed};
      end
      OP_SLTU: begin
        o_result = {{(XLEN_W-1){1'b0}}, w_lt_unsigned};
      end
      OP_LUI: begin
        o_result = w_upper_imm;
      end
      default: begin
        o_result = '0;  // NOP and unknown encodings
      end
    endcase
  end

endmodule

`default_nettype wire

// File: design/alu_operand_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module alu_operand_fwd (
  input  logic                             i_clk,
  input  logic                             i_reset_n,
  input  logic                             i_src_valid,
  input  logic [alu_pkg::RNID_W-1:0]       i_src_rnid,
  input  logic [alu_pkg::XLEN_W-1:0]       i_read_data,
  input  logic [alu_pkg::TGT_BUS_SIZE-1:0] i_fwd_valid,
  input  logic [alu_pkg::RNID_W-1:0]       i_fwd_rnid [alu_pkg::TGT_BUS_SIZE],
  input  logic [alu_pkg::XLEN_W-1:0]       i_fwd_data [alu_pkg::TGT_BUS_SIZE],
  output logic [alu_pkg::XLEN_W-1:0]       o_operand
);

  import alu_pkg::*;

  logic                    r_src_valid;
  logic [RNID_W-1:0]       r_src_rnid;
  logic [XLEN_W-1:0]       r_read_data;
  logic [TGT_BUS_SIZE-1:0] w_hit;
  logic [XLEN_W-1:0]       w_fwd_data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_src_valid <= 1'b0;
    end else begin
      r_src_valid <= i_src_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_src_rnid  <= i_src_rnid;
    r_read_data <= i_read_data;  // Register file or immediate
  end

  // --------------------------------------------------
  // EX2 bus match
  // --------------------------------------------------
  always_comb begin
    for (int i = 0; i < TGT_BUS_SIZE; i++) begin
      w_hit[i] = r_src_valid & i_fwd_valid[i] &
                 (i_fwd_rnid[i] == r_src_rnid) &
                 (r_src_rnid != '0);  // x0 is never forwarded
    end
  end

  always_comb begin
    w_fwd_data = '0;
    for (int i = 0; i < TGT_BUS_SIZE; i++) begin
      if (w_hit[i]) begin
        w_fwd_data = w_fwd_data | i_fwd_data[i];
      end
    end
  end

  assign o_operand = |w_hit ? w_fwd_data : r_read_data;

  // Other pipes never broadcast the same rnid together
  a_single_hit : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_hit)
  ) else $error("more than one result bus matches rnid %0d", r_src_rnid);

endmodule

`default_nettype wire

// File: design/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe (
  input  logic                              i_clk,
  input  logic                              i_reset_n,

  input  logic                              i_issue_valid,
  input  logic [31:0]                       i_issue_inst,
  input  logic                              i_issue_rs1_valid,
  input  logic [alu_pkg::RNID_W-1:0]        i_issue_rs1_rnid,
  input  logic                              i_issue_rs2_valid,
  input  logic [alu_pkg::RNID_W-1:0]        i_issue_rs2_rnid,
  input  logic                              i_issue_rd_valid,
  input  logic [alu_pkg::RNID_W-1:0]        i_issue_rd_rnid,
  input  logic [alu_pkg::BR_TAG_NUM-1:0]    i_issue_br_mask,
  input  logic [alu_pkg::RV_ENTRY_SIZE-1:0] i_issue_index,

  output logic                              o_rs1_read_valid,
  output logic [alu_pkg::RNID_W-1:0]        o_rs1_read_rnid,
  input  logic [alu_pkg::XLEN_W-1:0]        i_rs1_read_data,
  output logic                              o_rs2_read_valid,
  output logic [alu_pkg::RNID_W-1:0]        o_rs2_read_rnid,
  input  logic [alu_pkg::XLEN_W-1:0]        i_rs2_read_data,

  input  logic [alu_pkg::TGT_BUS_SIZE-1:0]  i_fwd_valid,
  input  logic [alu_pkg::RNID_W-1:0]        i_fwd_rnid [alu_pkg::TGT_BUS_SIZE],
  input  logic [alu_pkg::XLEN_W-1:0]        i_fwd_data [alu_pkg::TGT_BUS_SIZE],

  input  logic                              i_br_update,
  input  logic [alu_pkg::BR_TAG_W-1:0]      i_br_tag,
  input  logic                              i_br_mispredict,

  output logic                              o_early_wr_valid,
  output logic [alu_pkg::RNID_W-1:0]        o_early_wr_rnid,
  output logic                              o_wr_valid,
  output logic [alu_pkg::RNID_W-1:0]        o_wr_rnid,
  output logic [alu_pkg::XLEN_W-1:0]        o_wr_data,
  output logic                              o_done,
  output logic [alu_pkg::RV_ENTRY_SIZE-1:0] o_done_index
);

  import alu_pkg::*;

  op_t                    w_ex0_op;
  imm_t                   w_ex0_imm;

  logic                   w_ex1_valid;
  logic [BR_TAG_NUM-1:0]  w_ex1_br_mask;
  logic [31:0]            r_ex1_inst;
  op_t                    r_ex1_op;
  imm_t                   r_ex1_imm;
  logic                   r_ex1_rs1_valid;
  logic [RNID_W-1:0]      r_ex1_rs1_rnid;
  logic                   r_ex1_rs2_valid;
  logic [RNID_W-1:0]      r_ex1_rs2_rnid;
  logic                   r_ex1_rd_valid;
  logic [RNID_W-1:0]      r_ex1_rd_rnid;
  logic [RV_ENTRY_SIZE-1:0] r_ex1_index;
  logic [XLEN_W-1:0]      w_ex1_rs2_data;

  logic                   w_ex2_valid;
  logic [BR_TAG_NUM-1:0]  w_ex2_br_mask;
  logic [31:0]            r_ex2_inst;
  op_t                    r_ex2_op;
  logic [RNID_W-1:0]      r_ex2_rd_rnid;
  logic [RV_ENTRY_SIZE-1:0] r_ex2_index;
  logic                   r_ex2_wr_valid;
  logic [XLEN_W-1:0]      w_ex2_rs1;
  logic [XLEN_W-1:0]      w_ex2_rs2;
  logic [XLEN_W-1:0]      w_ex2_result;

  logic                   w_ex3_valid;
  logic [RNID_W-1:0]      r_ex3_rd_rnid;
  logic [RV_ENTRY_SIZE-1:0] r_ex3_index;
  logic                   r_ex3_wr_valid;
  logic [XLEN_W-1:0]      r_ex3_result;

  // --------------------------------------------------
  // EX0
  // --------------------------------------------------
  alu_decoder u_decoder (
    .i_inst (i_issue_inst),
    .o_op   (w_ex0_op),
    .o_imm  (w_ex0_imm)
  );

  alu_branch_kill u_kill_ex1 (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (i_issue_valid),
    .i_br_mask       (i_issue_br_mask),
    .i_br_update     (i_br_update),
    .i_br_tag        (i_br_tag),
    .i_br_mispredict (i_br_mispredict),
    .o_valid         (w_ex1_valid),
    .o_br_mask       (w_ex1_br_mask)
  );

  always_ff @(posedge i_clk) begin
    r_ex1_inst      <= i_issue_inst;
    r_ex1_op        <= w_ex0_op;
    r_ex1_imm       <= w_ex0_imm;
    r_ex1_rs1_valid <= i_issue_rs1_valid;
    r_ex1_rs1_rnid  <= i_issue_rs1_rnid;
    r_ex1_rs2_valid <= i_issue_rs2_valid;
    r_ex1_rs2_rnid  <= i_issue_rs2_rnid;
    r_ex1_rd_valid  <= i_issue_rd_valid;
    r_ex1_rd_rnid   <= i_issue_rd_rnid;
    r_ex1_index     <= i_issue_index;
  end

  // --------------------------------------------------
  // EX1
  // --------------------------------------------------
  assign o_rs1_read_valid = w_ex1_valid & r_ex1_rs1_valid;
  assign o_rs1_read_rnid  = r_ex1_rs1_rnid;
  assign o_rs2_read_valid = w_ex1_valid & r_ex1_rs2_valid;
  assign o_rs2_read_rnid  = r_ex1_rs2_rnid;

  assign o_early_wr_valid = w_ex1_valid & r_ex1_rd_valid;
  assign o_early_wr_rnid  = r_ex1_rd_rnid;

  always_comb begin
    case (r_ex1_imm)
      IMM_I:   w_ex1_rs2_data = {{(XLEN_W-12){r_ex1_inst[31]}}, r_ex1_inst[31:20]};
      IMM_SH:  w_ex1_rs2_data = {{(XLEN_W-SHAMT_W){1'b0}}, r_ex1_inst[24:20]};
      default: w_ex1_rs2_data = i_rs2_read_data;
    endcase
  end

  alu_branch_kill u_kill_ex2 (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (w_ex1_valid),
    .i_br_mask       (w_ex1_br_mask),
    .i_br_update     (i_br_update),
    .i_br_tag        (i_br_tag),
    .i_br_mispredict (i_br_mispredict),
    .o_valid         (w_ex2_valid),
    .o_br_mask       (w_ex2_br_mask)
  );

  alu_operand_fwd u_fwd_rs1 (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_src_valid (o_rs1_read_valid),
    .i_src_rnid  (r_ex1_rs1_rnid),
    .i_read_data (i_rs1_read_data),
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_rnid  (i_fwd_rnid),
    .i_fwd_data  (i_fwd_data),
    .o_operand   (w_ex2_rs1)
  );

  alu_operand_fwd u_fwd_rs2 (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_src_valid (o_rs2_read_valid),  // Low for immediate forms
    .i_src_rnid  (r_ex1_rs2_rnid),
    .i_read_data (w_ex1_rs2_data),
    .i_fwd_valid (i_fwd_valid),
    .i_fwd_rnid  (i_fwd_rnid),
    .i_fwd_data  (i_fwd_data),
    .o_operand   (w_ex2_rs2)
  );

  always_ff @(posedge i_clk) begin
    r_ex2_inst    <= r_ex1_inst;
    r_ex2_op      <= r_ex1_op;
    r_ex2_rd_rnid <= r_ex1_rd_rnid;
    r_ex2_index   <= r_ex1_index;
  end

  // --------------------------------------------------
  // EX2
  // --------------------------------------------------
  alu_exec u_exec (
    .i_op     (r_ex2_op),
    .i_inst   (r_ex2_inst),
    .i_rs1    (w_ex2_rs1),
    .i_rs2    (w_ex2_rs2),
    .o_result (w_ex2_result)
  );

  // Mask is no longer needed past EX3
  alu_branch_kill u_kill_ex3 (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_valid         (w_ex2_valid),
    .i_br_mask       (w_ex2_br_mask),
    .i_br_update     (i_br_update),
    .i_br_tag        (i_br_tag),
    .i_br_mispredict (i_br_mispredict),
    .o_valid         (w_ex3_valid),
    .o_br_mask       ()
  );

  // Write enable ignores later kills
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_wr_valid <= 1'b0;
      r_ex3_wr_valid <= 1'b0;
    end else begin
      r_ex2_wr_valid <= o_early_wr_valid;
      r_ex3_wr_valid <= r_ex2_wr_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_result  <= w_ex2_result;
    r_ex3_rd_rnid <= r_ex2_rd_rnid;
    r_ex3_index   <= r_ex2_index;
  end

  // --------------------------------------------------
  // EX3
  // --------------------------------------------------
  assign o_wr_valid   = r_ex3_wr_valid;
  assign o_wr_rnid    = r_ex3_rd_rnid;
  assign o_wr_data    = r_ex3_result;
  assign o_done       = w_ex3_valid;
  assign o_done_index = r_ex3_index;

  // Station index must survive three stages intact
  a_done_index_onehot : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_done |-> $onehot(o_done_index)
  ) else $error("done index %b is not one-hot", o_done_index);

endmodule

`default_nettype wire

// File: design/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int XLEN_W        = 32;
  localparam int RNID_W        = 6;
  localparam int BR_TAG_NUM    = 4;  // Also the branch mask width
  localparam int BR_TAG_W      = 2;
  localparam int TGT_BUS_SIZE  = 3;
  localparam int RV_ENTRY_SIZE = 8;  // One-hot station index
  localparam int SHAMT_W       = 5;

  // --------------------------------------------------
  // Major opcodes and funct3 fields
  // --------------------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111
  } opc_t;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // --------------------------------------------------
  // Pipe control
  // --------------------------------------------------
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_XOR  = 4'd3,
    OP_OR   = 4'd4,
    OP_AND  = 4'd5,
    OP_SLL  = 4'd6,
    OP_SRL  = 4'd7,
    OP_SRA  = 4'd8,
    OP_SLT  = 4'd9,
    OP_SLTU = 4'd10,
    OP_LUI  = 4'd11
  } op_t;

  // Source of the second operand
  typedef enum logic [1:0] {
    IMM_NONE = 2'd0,  // rs2
    IMM_I    = 2'd1,  // Sign-extended inst[31:20]
    IMM_SH   = 2'd2   // Zero-extended inst[24:20]
  } imm_t;

endpackage

`default_nettype wire

// File: tests/tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// Register file contents with x0 reading as zero
function automatic logic [31:0] reg_file_value(input logic [5:0] r);
  if (r == 6'd0) begin
    return 32'h0;
  end
  return {r, 2'b01, r, 2'b10, r, 2'b11, r, 2'b00} ^ 32'h5a3c_9617;
endfunction

// Decode and execute straight from the RV32I encoding
function automatic logic [31:0] rv32i_result(input logic [31:0] inst,
                                             input logic [31:0] a,
                                             input logic [31:0] rs2_val);
  logic [31:0] b;
  logic [2:0]  f3;
  logic        alt;
  f3  = inst[14:12];
  alt = inst[30];
  if (inst[6:0] == 7'b0110111) begin
    return {inst[31:12], 12'h000};
  end else if (inst[6:0] == 7'b0010011) begin
    if (f3 == 3'd1 || f3 == 3'd5) begin
      b = {27'b0, inst[24:20]};
    end else begin
      b = {{20{inst[31]}}, inst[31:20]};
    end
    alt = alt & (f3 == 3'd5);  // ADDI never subtracts
  end else if (inst[6:0] == 7'b0110011) begin
    b = rs2_val;
  end else begin
    return 32'h0;
  end
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: return (a < b) ? 32'd1 : 32'd0;
    3'd4: return a ^ b;
    3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_kills(input logic [3:0] mask, input logic [1:0] tag,
                                      input logic update, input logic mispredict);
  return update & mispredict & mask[tag];
endfunction

`endif

// File: tests/tb_alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_alu_pipe;

  import alu_pkg::*;

  `include "tb_alu_model.svh"

  typedef struct {
    logic        vld;
    logic [31:0] inst;
    logic        rs1v;
    logic [5:0]  rs1;
    logic        rs2v;
    logic [5:0]  rs2;
    logic        rdv;
    logic [5:0]  rd;
    logic [3:0]  mask;
    logic [7:0]  idx;
    logic        alive;
    logic        wr;
  } entry_t;

  logic i_clk;
  logic i_reset_n;
  logic i_issue_valid;
  logic [31:0] i_issue_inst;
  logic i_issue_rs1_valid;
  logic [RNID_W-1:0] i_issue_rs1_rnid;
  logic i_issue_rs2_valid;
  logic [RNID_W-1:0] i_issue_rs2_rnid;
  logic i_issue_rd_valid;
  logic [RNID_W-1:0] i_issue_rd_rnid;
  logic [BR_TAG_NUM-1:0] i_issue_br_mask;
  logic [RV_ENTRY_SIZE-1:0] i_issue_index;
  logic o_rs1_read_valid;
  logic [RNID_W-1:0] o_rs1_read_rnid;
  logic [XLEN_W-1:0] i_rs1_read_data;
  logic o_rs2_read_valid;
  logic [RNID_W-1:0] o_rs2_read_rnid;
  logic [XLEN_W-1:0] i_rs2_read_data;
  logic [TGT_BUS_SIZE-1:0] i_fwd_valid;
  logic [RNID_W-1:0] i_fwd_rnid [TGT_BUS_SIZE];
  logic [XLEN_W-1:0] i_fwd_data [TGT_BUS_SIZE];
  logic i_br_update;
  logic [BR_TAG_W-1:0] i_br_tag;
  logic i_br_mispredict;
  logic o_early_wr_valid;
  logic [RNID_W-1:0] o_early_wr_rnid;
  logic o_wr_valid;
  logic [RNID_W-1:0] o_wr_rnid;
  logic [XLEN_W-1:0] o_wr_data;
  logic o_done;
  logic [RV_ENTRY_SIZE-1:0] o_done_index;

  entry_t pipe_q[$];
  logic        exp_early;
  logic [5:0]  exp_early_rnid;
  logic        exp_rs1_rd;
  logic [5:0]  exp_rs1_rnid;
  logic        exp_rs2_rd;
  logic [5:0]  exp_rs2_rnid;
  logic        exp_done;
  logic        exp_wr;
  logic [5:0]  exp_rd;
  logic [31:0] exp_data;
  logic [7:0]  exp_idx;
  integer seed = 32'heb592345;
  int err_count = 0;
  int pass_count = 0;
  int issue_num = 0;

  alu_pipe dut_i (.*);

  assign i_rs1_read_data = reg_file_value(o_rs1_read_rnid);  // Combinational register file
  assign i_rs2_read_data = reg_file_value(o_rs2_read_rnid);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  initial begin
    #200us;
    $display("Simulation timed out");
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------
  // Scoreboard with index k captured k edges ago
  // --------------------------------------------------
  always @(posedge i_clk or negedge i_reset_n) begin
    entry_t e;
    logic [31:0] a;
    logic [31:0] b;
    if (!i_reset_n) begin
      pipe_q.delete();
      {exp_early, exp_early_rnid, exp_done, exp_wr, exp_rd, exp_data, exp_idx} = '0;
      {exp_rs1_rd, exp_rs1_rnid, exp_rs2_rd, exp_rs2_rnid} = '0;
    end else begin
      e = '{i_issue_valid, i_issue_inst, i_issue_rs1_valid, i_issue_rs1_rnid,
            i_issue_rs2_valid, i_issue_rs2_rnid, i_issue_rd_valid, i_issue_rd_rnid,
            i_issue_br_mask, i_issue_index, i_issue_valid, 1'b0};
      pipe_q.push_front(e);
      if (pipe_q.size() > 3) begin
        void'(pipe_q.pop_back());
      end
      for (int k = 0; k < pipe_q.size(); k++) begin
        if (branch_kills(pipe_q[k].mask, i_br_tag, i_br_update, i_br_mispredict)) begin
          pipe_q[k].alive = 1'b0;
        end
        if (i_br_update) begin
          pipe_q[k].mask[i_br_tag] = 1'b0;
        end
      end
      pipe_q[0].wr   = pipe_q[0].alive & pipe_q[0].rdv;
      pipe_q[0].rs1v = pipe_q[0].alive & pipe_q[0].rs1v;  // Sources read only when alive
      pipe_q[0].rs2v = pipe_q[0].alive & pipe_q[0].rs2v;
      exp_early      = pipe_q[0].wr;
      exp_early_rnid = pipe_q[0].rd;
      exp_rs1_rd     = pipe_q[0].rs1v;
      exp_rs1_rnid   = pipe_q[0].rs1;
      exp_rs2_rd     = pipe_q[0].rs2v;
      exp_rs2_rnid   = pipe_q[0].rs2;
      exp_done       = 1'b0;
      exp_wr         = 1'b0;
      if (pipe_q.size() == 3) begin
        e = pipe_q[2];
        a = reg_file_value(e.rs1);
        b = reg_file_value(e.rs2);
        for (int i = 0; i < TGT_BUS_SIZE; i++) begin
          if (i_fwd_valid[i] && i_fwd_rnid[i] != 0) begin
            if (e.rs1v && i_fwd_rnid[i] == e.rs1) a = i_fwd_data[i];
            if (e.rs2v && i_fwd_rnid[i] == e.rs2) b = i_fwd_data[i];
          end
        end
        exp_done = e.alive;
        exp_wr   = e.wr;
        exp_rd   = e.rd;
        exp_idx  = e.idx;
        exp_data = rv32i_result(e.inst, a, b);
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    err_count++;
    $display("[FAIL] t=%0t %s expected=%0h actual=%0h", $time, name, exp_v, act_v);
  endtask

  a_early : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_early_wr_valid == exp_early) pass_count++;
    else report_mismatch("o_early_wr_valid", exp_early, o_early_wr_valid);
  a_early_rnid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_early |-> o_early_wr_rnid == exp_early_rnid) pass_count++;
    else report_mismatch("o_early_wr_rnid", exp_early_rnid, o_early_wr_rnid);
  a_rs1_read : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rs1_read_valid == exp_rs1_rd) pass_count++;
    else report_mismatch("o_rs1_read_valid", exp_rs1_rd, o_rs1_read_valid);
  a_rs1_rnid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_rs1_rd |-> o_rs1_read_rnid == exp_rs1_rnid) pass_count++;
    else report_mismatch("o_rs1_read_rnid", exp_rs1_rnid, o_rs1_read_rnid);
  a_rs2_read : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_rs2_read_valid == exp_rs2_rd) pass_count++;
    else report_mismatch("o_rs2_read_valid", exp_rs2_rd, o_rs2_read_valid);
  a_rs2_rnid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_rs2_rd |-> o_rs2_read_rnid == exp_rs2_rnid) pass_count++;
    else report_mismatch("o_rs2_read_rnid", exp_rs2_rnid, o_rs2_read_rnid);
  a_done : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done == exp_done) pass_count++;
    else report_mismatch("o_done", exp_done, o_done);
  a_done_idx : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_done |-> o_done_index == exp_idx) pass_count++;
    else report_mismatch("o_done_index", exp_idx, o_done_index);
  a_wr : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_wr_valid == exp_wr) pass_count++;
    else report_mismatch("o_wr_valid", exp_wr, o_wr_valid);
  a_wr_rnid : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_wr |-> o_wr_rnid == exp_rd) pass_count++;
    else report_mismatch("o_wr_rnid", exp_rd, o_wr_rnid);
  a_wr_data : assert property (@(posedge i_clk) disable iff (!i_reset_n)
    exp_wr |-> o_wr_data == exp_data) pass_count++;
    else report_mismatch("o_wr_data", exp_data, o_wr_data);

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic tick();
    @(posedge i_clk);
    i_issue_valid <= 1'b0;
    i_br_update   <= 1'b0;
    i_fwd_valid   <= '0;
  endtask

  task automatic issue(input logic [31:0] inst, input logic [5:0] rs1,
                       input logic [5:0] rs2, input logic rs2v, input logic [3:0] mask);
    i_issue_valid     <= 1'b1;
    i_issue_inst      <= inst;
    i_issue_rs1_valid <= (inst[6:0] != 7'b0110111);
    i_issue_rs1_rnid  <= rs1;
    i_issue_rs2_valid <= rs2v;
    i_issue_rs2_rnid  <= rs2;
    i_issue_rd_valid  <= (issue_num % 7) != 6;  // Every seventh has no destination
    i_issue_rd_rnid   <= 6'($random(seed));
    i_issue_br_mask   <= mask;
    i_issue_index     <= 8'b1 << (issue_num % 8);
    issue_num++;
  endtask

  task automatic branch(input logic [1:0] tag, input logic mispredict);
    i_br_update     <= 1'b1;
    i_br_tag        <= tag;
    i_br_mispredict <= mispredict;
  endtask

  task automatic drain(input string name);
    int t;
    bit busy;
    t = 0;
    do begin
      tick();
      #1;
      busy = 0;
      foreach (pipe_q[k]) busy |= pipe_q[k].vld;
      t++;
    end while ((busy || pipe_q.size() < 3) && t < 20);
    if (t >= 20) begin
      err_count++;
      $display("Pipe did not drain within 20 cycles in test %s", name);
    end
    $display("Test %s finished, failures so far %0d", name, err_count);
  endtask

  function automatic logic [31:0] r_inst(input logic [2:0] f3, input logic alt);
    return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_inst(input logic [2:0] f3, input logic [11:0] imm);
    return {imm, 5'd1, f3, 5'd3, 7'b0010011};
  endfunction

  initial begin
    logic [3:0] ops [10];
    ops = '{4'h0, 4'h8, 4'h1, 4'h2, 4'h3, 4'h4, 4'h5, 4'hd, 4'h6, 4'h7};
    i_reset_n = 1'b0;
    {i_issue_valid, i_issue_inst, i_issue_rs1_valid, i_issue_rs1_rnid} = '0;
    {i_issue_rs2_valid, i_issue_rs2_rnid, i_issue_rd_valid, i_issue_rd_rnid} = '0;
    {i_issue_br_mask, i_issue_index, i_fwd_valid} = '0;
    {i_br_update, i_br_tag, i_br_mispredict} = '0;
    for (int i = 0; i < TGT_BUS_SIZE; i++) begin
      i_fwd_rnid[i] = '0;
      i_fwd_data[i] = '0;
    end
    for (int c = 0; c < 6; c++) begin
      @(posedge i_clk);
      if (c == 2) i_reset_n <= 1'b1;  // Held for 3 cycles
      #1;
      assert (!o_done && !o_wr_valid && !o_early_wr_valid &&
              !o_rs1_read_valid && !o_rs2_read_valid)
      else begin
        err_count++;
        $display("An output valid is high during or right after reset");
      end
    end
    $display("Test reset finished, failures so far %0d", err_count);

    // Bit 3 of ops selects bit 30 and the rest is funct3
    for (int n = 0; n < 30; n++) begin
      tick();
      issue(r_inst(ops[n % 10][2:0], ops[n % 10][3]), 6'($random(seed)),
            6'($random(seed)), 1'b1, 4'h0);
    end
    drain("reg_reg");

    for (int n = 0; n < 4; n++) begin
      tick();
      issue(imm_inst(3'd0, 12'($random(seed))), 6'($random(seed)), 6'd0, 1'b0, 4'h0);
      tick();
      issue(imm_inst(3'd2, 12'($random(seed))), 6'($random(seed)), 6'd0, 1'b0, 4'h0);
      tick();
      issue(imm_inst(3'd1, {7'b0, 5'($random(seed))}), 6'($random(seed)), 6'd0, 1'b0, 4'h0);
      tick();
      issue(imm_inst(3'd5, {7'b0100000, 5'($random(seed))}), 6'($random(seed)), 6'd0,
            1'b0, 4'h0);
      tick();
      issue({20'($random(seed)), 5'd3, 7'b0110111}, 6'd0, 6'd0, 1'b0, 4'h0);
    end
    drain("immediate");

    tick();
    issue(r_inst(3'd0, 1'b0), 6'd5, 6'd6, 1'b1, 4'h0);
    tick();
    issue(r_inst(3'd4, 1'b0), 6'd0, 6'd7, 1'b1, 4'h0);
    tick();
    i_fwd_valid   <= 3'b101;  // rs1 on bus 0 and rs2 on bus 2
    i_fwd_rnid[0] <= 6'd5;
    i_fwd_data[0] <= 32'($random(seed));
    i_fwd_rnid[2] <= 6'd6;
    i_fwd_data[2] <= 32'($random(seed));
    tick();
    i_fwd_valid   <= 3'b010;  // x0 must be ignored
    i_fwd_rnid[1] <= 6'd0;
    i_fwd_data[1] <= 32'hdead_beef;
    drain("forward");

    for (int s = 0; s < 3; s++) begin
      tick();
      issue(r_inst(3'd0, 1'b0), 6'd9, 6'd10, 1'b1, 4'b0100);
      if (s == 0) branch(2'd2, 1'b1);
      for (int d = 1; d <= s; d++) begin
        tick();
        if (d == s) branch(2'd2, 1'b1);
      end
      drain("kill");
    end
    tick();
    issue(r_inst(3'd7, 1'b0), 6'd11, 6'd12, 1'b1, 4'b0010);
    tick();
    branch(2'd1, 1'b0);
    tick();
    branch(2'd1, 1'b1);  // Bit already cleared
    drain("kill_cleared");

    $display("Summary: %0d assertion passes, %0d failures", pass_count, err_count);
    if (err_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
